// ==== Bender.yml ====
package:
  name: flow_detect

sources:
  - src/flow_pkg.sv
  - src/eth_pkg.sv
  - src/stream_reg.sv
  - src/hdr_parser.sv
  - src/rule_table.sv
  - src/rule_scan_counter.sv
  - src/match_fsm.sv
  - src/tuple_matcher.sv
  - src/flow_detect_top.sv
  - target: test
    files:
      - dv/flow_detect_props.sv
      - dv/flow_checker.sv
      - dv/tb_flow_detect.sv

// ==== compile.f ====
src/flow_pkg.sv
src/eth_pkg.sv
src/stream_reg.sv
src/hdr_parser.sv
src/rule_table.sv
src/rule_scan_counter.sv
src/match_fsm.sv
src/tuple_matcher.sv
src/flow_detect_top.sv
dv/flow_detect_props.sv
dv/flow_checker.sv
dv/tb_flow_detect.sv

// ==== dv/flow_checker.sv ====
/*
 * Scoreboard for the flow detector. Tracks accepted input bytes and
 * expected flow numbers, and compares them with the DUT outputs.
 */
`default_nettype none

module flow_checker
  import flow_pkg::*;
  import eth_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  logic [BYTE_W-1:0] s_data,
  input  logic              s_last,
  input  logic              s_valid,
  input  logic              s_ready,
  input  logic [BYTE_W-1:0] m_data,
  input  logic              m_last,
  input  logic              m_valid,
  input  logic              m_ready,
  input  logic [FLOW_W-1:0] flow,
  input  logic              flow_valid,
  input  logic              flow_ready,
  input  logic [FLOW_W-1:0] exp_flow,
  input  logic              exp_push,
  output int                errors,
  output int                results,
  output int                pending
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [BYTE_W:0]   byte_q [$];
  logic [FLOW_W-1:0] flow_q [$];
  logic [BYTE_W:0]   exp_byte;
  logic [FLOW_W-1:0] exp_f;
  int                err_cnt;
  int                res_cnt;

  always @(posedge clk) begin
    if (!rstn) begin
      byte_q.delete();
      flow_q.delete();
      err_cnt = 0;
      res_cnt = 0;
    end else begin
      if (exp_push) flow_q.push_back(exp_flow);
      if (s_valid && s_ready) byte_q.push_back({s_last, s_data});

      // ------------------------------------------------------------
      // Stream pass-through
      // ------------------------------------------------------------
      if (m_valid && m_ready) begin
        if (byte_q.size() == 0) begin
          $display("Output byte at %0t ns with no input byte pending", $time);
          err_cnt++;
        end else begin
          exp_byte = byte_q.pop_front();
          if (m_data !== exp_byte[BYTE_W-1:0]) begin
            $display("Mismatch at %0t ns on m_data: expected 0x%02h, actual 0x%02h",
                     $time, exp_byte[BYTE_W-1:0], m_data);
            err_cnt++;
          end
          if (m_last !== exp_byte[BYTE_W]) begin
            $display("Mismatch at %0t ns on m_last: expected %0b, actual %0b",
                     $time, exp_byte[BYTE_W], m_last);
            err_cnt++;
          end
        end
      end

      // ------------------------------------------------------------
      // Flow results, one per frame in order
      // ------------------------------------------------------------
      if (flow_valid && flow_ready) begin
        res_cnt++;
        if (flow_q.size() == 0) begin
          $display("Flow result %0d at %0t ns arrived with no frame waiting for one",
                   flow, $time);
          err_cnt++;
        end else begin
          exp_f = flow_q.pop_front();
          if (flow !== exp_f) begin
            $display("Mismatch at %0t ns on flow: expected %0d, actual %0d",
                     $time, exp_f, flow);
            err_cnt++;
          end
          $display("Result %0d: flow %0d, expected %0d, %s",
                   res_cnt, flow, exp_f, (flow === exp_f) ? "ok" : "wrong");
        end
      end
    end
    errors  <= err_cnt;
    results <= res_cnt;
    pending <= byte_q.size() + flow_q.size();
  end

endmodule

`default_nettype wire

// ==== dv/flow_detect_props.sv ====
/*
 * Handshake properties for the flow detector outputs.
 * Bound into the top level from the testbench.
 */
`default_nettype none

module flow_detect_props
  import flow_pkg::*;
  import eth_pkg::*;
(
  input logic              clk,
  input logic              rstn,
  input logic [BYTE_W-1:0] m_data,
  input logic              m_last,
  input logic              m_valid,
  input logic              m_ready,
  input logic [FLOW_W-1:0] flow,
  input logic              flow_valid,
  input logic              flow_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  int assert_fails = 0;

  // Stalled outputs keep valid and payload
  a_m_hold: assert property (@(posedge clk) disable iff (!rstn)
    m_valid && !m_ready |=> m_valid && $stable({m_last, m_data}))
  else begin
    $error("m_valid dropped or stream payload changed while stalled");
    assert_fails++;
  end

  a_flow_hold: assert property (@(posedge clk) disable iff (!rstn)
    flow_valid && !flow_ready |=> flow_valid && $stable(flow))
  else begin
    $error("flow_valid dropped or flow changed while stalled");
    assert_fails++;
  end

  a_reset_idle: assert property (@(posedge clk) !rstn |=> !m_valid && !flow_valid)
  else begin
    $error("output valid high in the cycle after reset");
    assert_fails++;
  end

endmodule

`default_nettype wire

// ==== dv/tb_flow_detect.sv ====
/*
 * Testbench for the flow detector. Writes a rule set, sends a table of
 * frames under random back-pressure and reports per-result status.
 */
`default_nettype none

module tb_flow_detect
  import flow_pkg::*;
  import eth_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int FLOW_NUM   = 16;
  localparam int FLOW_BITS  = $clog2(FLOW_NUM);
  localparam int HOLD_STALL = 2 * FLOW_NUM;

  typedef struct {
    logic [15:0] vlan;
    logic [15:0] etype;
    logic [7:0]  proto;
    flow_tuple_t tup;
    int          len;
    int          exp;
    bit          hold;
  } frame_row_t;

  logic                    clk;
  logic                    rstn;
  logic [BYTE_W-1:0]       s_data;
  logic                    s_last;
  logic                    s_valid;
  logic                    s_ready;
  logic [BYTE_W-1:0]       m_data;
  logic                    m_last;
  logic                    m_valid;
  logic                    m_ready;
  logic [FLOW_W-1:0]       flow;
  logic                    flow_valid;
  logic                    flow_ready;
  logic                    rule_we;
  logic [FLOW_BITS-1:0]    rule_idx;
  rule_field_e             rule_field;
  logic [RULE_WDATA_W-1:0] rule_wdata;
  logic [FLOW_W-1:0]       exp_flow;
  logic                    exp_push;
  int                      errors;
  int                      results;
  int                      pending;
  integer                  seed = 32'h73ee_f587;
  bit                      hold_flow;
  frame_row_t              rows [$];

  flow_detect_top #(.FLOW_NUM(FLOW_NUM)) u_dut (
    .clk(clk), .rstn(rstn),
    .s_data(s_data), .s_last(s_last), .s_valid(s_valid), .s_ready(s_ready),
    .m_data(m_data), .m_last(m_last), .m_valid(m_valid), .m_ready(m_ready),
    .flow(flow), .flow_valid(flow_valid), .flow_ready(flow_ready),
    .rule_we(rule_we), .rule_idx(rule_idx), .rule_field(rule_field),
    .rule_wdata(rule_wdata)
  );

  flow_checker u_checker (
    .clk(clk), .rstn(rstn),
    .s_data(s_data), .s_last(s_last), .s_valid(s_valid), .s_ready(s_ready),
    .m_data(m_data), .m_last(m_last), .m_valid(m_valid), .m_ready(m_ready),
    .flow(flow), .flow_valid(flow_valid), .flow_ready(flow_ready),
    .exp_flow(exp_flow), .exp_push(exp_push),
    .errors(errors), .results(results), .pending(pending)
  );

  bind flow_detect_top flow_detect_props u_props (
    .clk(clk), .rstn(rstn),
    .m_data(m_data), .m_last(m_last), .m_valid(m_valid), .m_ready(m_ready),
    .flow(flow), .flow_valid(flow_valid), .flow_ready(flow_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic void add_row(input logic [15:0] vlan, input logic [15:0] etype,
                                  input logic [7:0] proto, input logic [31:0] sip,
                                  input int sp, input logic [31:0] dip, input int dp,
                                  input int len, input int exp, input bit hold);
    frame_row_t r;
    r.vlan  = vlan;
    r.etype = etype;
    r.proto = proto;
    r.tup   = {sip, 16'(sp), dip, 16'(dp)};
    r.len   = len;
    r.exp   = exp;
    r.hold  = hold;
    rows.push_back(r);
  endfunction

  // Expected flows follow the first-match order of the rules written below
  function automatic void build_rows();
    add_row(0, ETYPE_IPV4, PROTO_TCP, 32'hC0A80101, 1234, 32'hC0A80202, 443, 60, 4, 0);
    add_row(0, ETYPE_IPV4, PROTO_TCP, 32'h0A000001, 4369, 32'h0A0000FE, 80, 64, 3, 0);
    add_row(ETYPE_VLAN, ETYPE_IPV4, PROTO_UDP, 32'h0B000001, 39321, 32'hAC100005, 53, 70, 7, 0);
    add_row(ETYPE_QINQ, ETYPE_IPV4, PROTO_UDP, 32'h0A0A0A0A, 8738, 32'h08080808, 8080, 66, 1, 0);
    add_row(0, 16'h0806, 8'd0, 32'hC0A80101, 1234, 32'hC0A80202, 443, 60, 0, 0);
    add_row(0, ETYPE_IPV4, 8'd1, 32'hC0A80101, 1234, 32'hC0A80202, 443, 60, 0, 0);
    add_row(0, ETYPE_IPV4, PROTO_TCP, 32'h0A000001, 21845, 32'h01010101, 80, 60, 3, 0);
    add_row(0, ETYPE_IPV4, PROTO_UDP, 32'h0C000001, 4096, 32'h0D000001, 8192, 60, 16, 0);
    add_row(0, ETYPE_IPV4, PROTO_TCP, 32'hC0A80101, 1234, 32'hC0A80202, 443, 60, 4, 1);
    add_row(ETYPE_VLAN, ETYPE_IPV4, PROTO_UDP, 32'h0B000001, 39321, 32'hAC100005, 53, 64, 7, 1);
    add_row(0, ETYPE_IPV4, PROTO_TCP, 32'hC0A80101, 1234, 32'hC0A80202, 443, 42, -1, 0);
    add_row(0, ETYPE_IPV4, PROTO_UDP, 32'h0A000001, 1, 32'h0A0000FE, 80, 43, 3, 0);
  endfunction

  // Byte k of a frame on the wire
  function automatic logic [7:0] frame_byte(input frame_row_t r, input int k);
    int          base;
    logic [95:0] wire_tup;
    base     = (r.vlan != 16'h0) ? 4 : 0;
    wire_tup = {r.tup.src_ip, r.tup.dst_ip, r.tup.src_port, r.tup.dst_port};
    if (k < 12) return 8'h20 + 8'(k);
    if (base != 0 && k == 12) return r.vlan[15:8];
    if (base != 0 && k == 13) return r.vlan[7:0];
    if (base != 0 && k < 16) return 8'(k * 5);
    if (k == 12 + base) return r.etype[15:8];
    if (k == 13 + base) return r.etype[7:0];
    if (k == 14 + base) return 8'h45;
    if (k == 23 + base) return r.proto;
    if (k >= 26 + base && k < 38 + base) return wire_tup[95 - 8 * (k - 26 - base) -: 8];
    return 8'(k * 13 + 7);
  endfunction

  task automatic write_field(input int idx, input rule_field_e f, input logic [31:0] d);
    rule_we    = 1'b1;
    rule_idx   = idx[FLOW_BITS-1:0];
    rule_field = f;
    rule_wdata = d;
    @(posedge clk);
    #1;
    rule_we = 1'b0;
  endtask

  task automatic write_rule(input int idx, input logic [31:0] sip, input int sp,
                            input logic [31:0] dip, input int dp);
    write_field(idx, SRC_IP, sip);
    write_field(idx, SRC_PORT, 32'(sp));
    write_field(idx, DST_IP, dip);
    write_field(idx, DST_PORT, 32'(dp));
  endtask

  task automatic send_frame(input frame_row_t r, input int num);
    int stall;
    hold_flow = r.hold;
    if (r.exp >= 0) begin
      exp_flow = 8'(r.exp);
      exp_push = 1'b1;
      @(posedge clk);
      #1;
      exp_push = 1'b0;
    end
    for (int k = 0; k < r.len; k++) begin
      s_data  = frame_byte(r, k);
      s_last  = (k == r.len - 1);
      s_valid = 1'b1;
      stall   = 0;
      @(posedge clk);
      while (!s_ready) begin
        stall++;
        // Let held flow results drain once the stream has stalled
        if (stall == HOLD_STALL) hold_flow = 1'b0;
        @(posedge clk);
      end
      #1;
    end
    s_valid = 1'b0;
    s_last  = 1'b0;
    if (r.exp < 0) $display("Frame %0d: %0d bytes sent, no flow result expected", num, r.len);
  endtask

  // Random output back-pressure
  initial begin
    wait (rstn);
    forever begin
      @(posedge clk);
      #1;
      m_ready    = ($random(seed) & 3) != 0;
      flow_ready = !hold_flow && (($random(seed) & 1) != 0);
    end
  end

  initial begin : watchdog
    int limit;
    limit = 200;
    @(posedge clk);
    foreach (rows[i]) limit += (rows[i].len + FLOW_NUM + 40) * 4;
    repeat (limit) @(posedge clk);
    $display("Run timed out after %0d cycles with %0d items still pending", limit, pending);
    $display("Checks failed");
    $finish;
  end

  initial begin : main
    int n_exp;
    int total;
    rstn = 1'b0;
    s_data = '0;
    s_last = 1'b0;
    s_valid = 1'b0;
    m_ready = 1'b0;
    flow_ready = 1'b0;
    rule_we = 1'b0;
    rule_idx = '0;
    rule_field = SRC_IP;
    rule_wdata = '0;
    exp_flow = '0;
    exp_push = 1'b0;
    hold_flow = 1'b0;
    n_exp = 0;
    build_rows();
    repeat (16) @(posedge clk);
    #1;
    rstn = 1'b1;

    write_rule(0, 32'h0A0A0A0A, 0, 32'h0, 0);
    write_rule(2, 32'h0A000001, 0, 32'h0, 80);
    write_rule(3, 32'hC0A80101, 1234, 32'hC0A80202, 443);
    write_rule(5, 32'h0A000001, 4369, 32'h0A0000FE, 80);
    write_rule(6, 32'h0, 0, 32'hAC100005, 53);
    // Reserved entry must stay all-zero
    write_field(FLOW_NUM - 1, SRC_IP, 32'h01020304);

    foreach (rows[i]) begin
      if (rows[i].exp >= 0) n_exp++;
      send_frame(rows[i], i);
    end
    hold_flow = 1'b0;

    @(posedge clk);
    while (pending != 0) @(posedge clk);
    repeat (40) @(posedge clk);

    total = errors + u_dut.u_props.assert_fails;
    if (results != n_exp) begin
      $display("Expected %0d flow results but received %0d", n_exp, results);
      total++;
    end
    $display("Summary: %0d frames, %0d of %0d flow results, %0d errors",
             rows.size(), results, n_exp, total);
    if (total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/eth_pkg.sv ====
/*
 * Ethernet and IPv4 header constants and byte offsets within the frame.
 */
`default_nettype none

package eth_pkg;

  localparam int BYTE_W    = 8;
  localparam int HDR_BYTES = 42;

  localparam logic [15:0] ETYPE_IPV4 = 16'h0800;
  localparam logic [15:0] ETYPE_VLAN = 16'h8100;
  localparam logic [15:0] ETYPE_QINQ = 16'h9100;

  localparam logic [7:0] PROTO_TCP = 8'd6;
  localparam logic [7:0] PROTO_UDP = 8'd17;

  // Tagged offsets are shifted by the 4-byte VLAN tag
  localparam int OFS_ETYPE      = 12;
  localparam int OFS_ETYPE_VLAN = 16;
  localparam int OFS_PROTO      = 23;
  localparam int OFS_PROTO_VLAN = 27;
  localparam int OFS_TUPLE      = 26;
  localparam int OFS_TUPLE_VLAN = 30;

endpackage

`default_nettype wire

// ==== src/flow_detect_top.sv ====
/*
 * Flow detector top level. Byte stream pass-through with a per-frame
 * flow result from a first-match scan of the rule table.
 */
`default_nettype none

module flow_detect_top
  import flow_pkg::*;
  import eth_pkg::*;
#(
  parameter int FLOW_NUM  = 16,
  localparam int FLOW_BITS = $clog2(FLOW_NUM)
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic [BYTE_W-1:0]       s_data,
  input  logic                    s_last,
  input  logic                    s_valid,
  output logic                    s_ready,
  output logic [BYTE_W-1:0]       m_data,
  output logic                    m_last,
  output logic                    m_valid,
  input  logic                    m_ready,
  output logic [FLOW_W-1:0]       flow,
  output logic                    flow_valid,
  input  logic                    flow_ready,
  input  logic                    rule_we,
  input  logic [FLOW_BITS-1:0]    rule_idx,
  input  rule_field_e             rule_field,
  input  logic [RULE_WDATA_W-1:0] rule_wdata
);

  flow_tuple_t          tuple;
  logic                 tuple_l4;
  logic                 tuple_valid;
  logic                 tuple_ready;
  logic                 scan_start;
  logic                 load;
  logic                 scan_done;
  logic                 rd_en;
  logic [FLOW_BITS-1:0] rd_idx;
  flow_tuple_t          rule;
  logic                 rule_valid;
  logic [FLOW_BITS-1:0] rule_idx_q;
  logic [FLOW_W-1:0]    match_flow;

  hdr_parser u_parser (
    .clk         (clk),
    .rstn        (rstn),
    .s_data      (s_data),
    .s_last      (s_last),
    .s_valid     (s_valid),
    .s_ready     (s_ready),
    .m_data      (m_data),
    .m_last      (m_last),
    .m_valid     (m_valid),
    .m_ready     (m_ready),
    .tuple       (tuple),
    .tuple_l4    (tuple_l4),
    .tuple_valid (tuple_valid),
    .tuple_ready (tuple_ready)
  );

  match_fsm u_fsm (
    .clk         (clk),
    .rstn        (rstn),
    .tuple_valid (tuple_valid),
    .tuple_l4    (tuple_l4),
    .tuple_ready (tuple_ready),
    .scan_start  (scan_start),
    .load        (load),
    .scan_done   (scan_done),
    .flow        (match_flow),
    .flow_out    (flow),
    .flow_valid  (flow_valid),
    .flow_ready  (flow_ready)
  );

  // ------------------------------------------------------------
  // Rule scan path
  // ------------------------------------------------------------
  rule_scan_counter #(.FLOW_NUM(FLOW_NUM)) u_counter (
    .clk        (clk),
    .rstn       (rstn),
    .scan_start (scan_start),
    .rd_en      (rd_en),
    .rd_idx     (rd_idx),
    .rule_valid (rule_valid),
    .rule_idx_q (rule_idx_q),
    .scan_done  (scan_done)
  );

  rule_table #(.FLOW_NUM(FLOW_NUM)) u_table (
    .clk        (clk),
    .rstn       (rstn),
    .rule_we    (rule_we),
    .rule_idx   (rule_idx),
    .rule_field (rule_field),
    .rule_wdata (rule_wdata),
    .rd_en      (rd_en),
    .rd_idx     (rd_idx),
    .rule       (rule)
  );

  tuple_matcher #(.FLOW_NUM(FLOW_NUM)) u_matcher (
    .clk        (clk),
    .rstn       (rstn),
    .load       (load),
    .tuple      (tuple),
    .rule       (rule),
    .rule_valid (rule_valid),
    .rule_idx_q (rule_idx_q),
    .flow       (match_flow)
  );

endmodule

`default_nettype wire

// ==== src/flow_pkg.sv ====
/*
 * Flow table definitions shared by the parser, rule table and matcher.
 * Covers tuple layout, result width and rule field select codes.
 */
`default_nettype none

package flow_pkg;

  localparam int IP_W         = 32;
  localparam int PORT_W       = 16;
  localparam int FLOW_W       = 8;
  localparam int RULE_WDATA_W = 32;

  // MSB first: src_ip, src_port, dst_ip, dst_port
  typedef struct packed {
    logic [IP_W-1:0]   src_ip;
    logic [PORT_W-1:0] src_port;
    logic [IP_W-1:0]   dst_ip;
    logic [PORT_W-1:0] dst_port;
  } flow_tuple_t;

  // Field targeted by one rule write
  typedef enum logic [1:0] {
    SRC_IP   = 2'd0,
    SRC_PORT = 2'd1,
    DST_IP   = 2'd2,
    DST_PORT = 2'd3
  } rule_field_e;

endpackage

`default_nettype wire

// ==== src/hdr_parser.sv ====
/*
 * Header parser. Passes the byte stream through one register stage and
 * extracts the IPv4 4-tuple from the first 42 bytes of each frame.
 */
`default_nettype none

module hdr_parser
  import flow_pkg::*;
  import eth_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  logic [BYTE_W-1:0] s_data,
  input  logic              s_last,
  input  logic              s_valid,
  output logic              s_ready,
  output logic [BYTE_W-1:0] m_data,
  output logic              m_last,
  output logic              m_valid,
  input  logic              m_ready,
  output flow_tuple_t       tuple,
  output logic              tuple_l4,
  output logic              tuple_valid,
  input  logic              tuple_ready
);

  localparam int WIN_W   = HDR_BYTES * BYTE_W;
  localparam int TUPLE_W = $bits(flow_tuple_t);

  logic              data_ready;
  logic [BYTE_W:0]   data_out;
  logic              accept;
  logic              hdr_hit;
  logic [WIN_W-1:0]  win;
  logic [HDR_BYTES:0] fill;
  logic              vlan;
  logic [15:0]       etype_outer;
  logic [15:0]       etype_inner;
  logic [BYTE_W-1:0] proto;
  logic              is_l4;
  logic [TUPLE_W-1:0] tuple_raw;
  logic [TUPLE_W-1:0] tuple_be;

  assign s_ready = data_ready && (!tuple_valid || tuple_ready);
  assign accept  = s_valid && s_ready;

  stream_reg #(
    .payload_t (logic [BYTE_W:0])
  ) u_data_reg (
    .clk       (clk),
    .rstn      (rstn),
    .in        ({s_last, s_data}),
    .in_valid  (accept),
    .in_ready  (data_ready),
    .out       (data_out),
    .out_valid (m_valid),
    .out_ready (m_ready)
  );

  assign {m_last, m_data} = data_out;

  // ------------------------------------------------------------
  // Header window, oldest byte in the low bits
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      fill <= '0;
    end else if (accept) begin
      fill <= s_last ? '0 : {1'b1, fill[HDR_BYTES:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      win <= s_last ? '0 : {s_data, win[WIN_W-1:BYTE_W]};
    end
  end

  // 42 bytes held and the 43rd being accepted
  assign hdr_hit = accept && (&fill[HDR_BYTES:1]) && !fill[0];

  // Header fields are big-endian on the wire
  assign etype_outer = {<<BYTE_W{win[OFS_ETYPE*BYTE_W +: 16]}};
  assign etype_inner = {<<BYTE_W{win[OFS_ETYPE_VLAN*BYTE_W +: 16]}};
  assign vlan  = (etype_outer == ETYPE_VLAN) || (etype_outer == ETYPE_QINQ);
  assign proto = vlan ? win[OFS_PROTO_VLAN*BYTE_W +: BYTE_W] : win[OFS_PROTO*BYTE_W +: BYTE_W];
  assign is_l4 = ((vlan ? etype_inner : etype_outer) == ETYPE_IPV4) &&
                 ((proto == PROTO_TCP) || (proto == PROTO_UDP));

  assign tuple_raw = vlan ? win[OFS_TUPLE_VLAN*BYTE_W +: TUPLE_W]
                          : win[OFS_TUPLE*BYTE_W +: TUPLE_W];
  // Wire order is src_ip, dst_ip, src_port, dst_port
  assign tuple_be  = {<<BYTE_W{tuple_raw}};

  always_ff @(posedge clk) begin
    if (!rstn) begin
      tuple_valid <= 1'b0;
    end else if (hdr_hit) begin
      tuple_valid <= 1'b1;
    end else if (tuple_ready) begin
      tuple_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_hit) begin
      tuple    <= {tuple_be[95:64], tuple_be[31:16], tuple_be[63:32], tuple_be[15:0]};
      tuple_l4 <= is_l4;
    end
  end

endmodule

`default_nettype wire

// ==== src/match_fsm.sv ====
/*
 * Match sequencer. Takes a tuple, runs a scan for TCP/UDP frames and
 * pushes one flow result per frame into the output register.
 */
`default_nettype none

module match_fsm
  import flow_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  logic              tuple_valid,
  input  logic              tuple_l4,
  output logic              tuple_ready,
  output logic              scan_start,
  output logic              load,
  input  logic              scan_done,
  input  logic [FLOW_W-1:0] flow,
  output logic [FLOW_W-1:0] flow_out,
  output logic              flow_valid,
  input  logic              flow_ready
);

  typedef enum logic [1:0] {WAIT, MATCH, SEND, SEND_NONE} state_e;

  state_e            state;
  logic              res_valid;
  logic              res_ready;
  logic [FLOW_W-1:0] res;

  assign tuple_ready = (state == WAIT);
  assign load        = tuple_valid && tuple_ready;
  assign scan_start  = load && tuple_l4;

  assign res_valid = (state == SEND) || (state == SEND_NONE);
  // Frames that are not IPv4 TCP/UDP report flow 0
  assign res       = (state == SEND) ? flow : '0;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= WAIT;
    end else begin
      case (state)
        WAIT:      if (tuple_valid) state <= tuple_l4 ? MATCH : SEND_NONE;
        MATCH:     if (scan_done) state <= SEND;
        SEND,
        SEND_NONE: if (res_ready) state <= WAIT;
        default:   state <= WAIT;
      endcase
    end
  end

  stream_reg #(
    .payload_t (logic [FLOW_W-1:0])
  ) u_flow_reg (
    .clk       (clk),
    .rstn      (rstn),
    .in        (res),
    .in_valid  (res_valid),
    .in_ready  (res_ready),
    .out       (flow_out),
    .out_valid (flow_valid),
    .out_ready (flow_ready)
  );

endmodule

`default_nettype wire

// ==== src/rule_scan_counter.sv ====
/*
 * Scan sequencer. Steps the rule index once over the table and keeps the
 * index aligned with the registered table output.
 */
`default_nettype none

module rule_scan_counter #(
  parameter int FLOW_NUM  = 16,
  localparam int FLOW_BITS = $clog2(FLOW_NUM)
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 scan_start,
  output logic                 rd_en,
  output logic [FLOW_BITS-1:0] rd_idx,
  output logic                 rule_valid,
  output logic [FLOW_BITS-1:0] rule_idx_q,
  output logic                 scan_done
);

  localparam logic [FLOW_BITS-1:0] LAST_IDX = FLOW_BITS'(FLOW_NUM - 1);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_en      <= 1'b0;
      rd_idx     <= '0;
      rule_valid <= 1'b0;
      scan_done  <= 1'b0;
    end else begin
      rule_valid <= rd_en;
      // Falling edge of the delayed enable ends the scan
      scan_done  <= rule_valid && !rd_en;
      if (scan_start) begin
        rd_en  <= 1'b1;
        rd_idx <= '0;
      end else if (rd_en) begin
        rd_idx <= rd_idx + 1'b1;
        if (rd_idx == LAST_IDX) begin
          rd_en <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    rule_idx_q <= rd_idx;
  end

endmodule

`default_nettype wire

// ==== src/rule_table.sv ====
/*
 * Rule table. Written one field per strobe, read one entry per cycle
 * during a scan. The last entry is a fixed all-zero catch-all.
 */
`default_nettype none

module rule_table
  import flow_pkg::*;
#(
  parameter int FLOW_NUM  = 16,
  localparam int FLOW_BITS = $clog2(FLOW_NUM)
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    rule_we,
  input  logic [FLOW_BITS-1:0]    rule_idx,
  input  rule_field_e             rule_field,
  input  logic [RULE_WDATA_W-1:0] rule_wdata,
  input  logic                    rd_en,
  input  logic [FLOW_BITS-1:0]    rd_idx,
  output flow_tuple_t             rule
);

  localparam logic [FLOW_BITS-1:0] LAST_IDX = FLOW_BITS'(FLOW_NUM - 1);

  flow_tuple_t rules [FLOW_NUM];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      // Unwritten rules never match a real tuple
      for (int i = 0; i < FLOW_NUM; i++) begin
        rules[i] <= (i == FLOW_NUM - 1) ? '0 : '1;
      end
    end else if (rule_we && (rule_idx != LAST_IDX)) begin
      case (rule_field)
        SRC_IP:   rules[rule_idx].src_ip   <= rule_wdata;
        SRC_PORT: rules[rule_idx].src_port <= rule_wdata[PORT_W-1:0];
        DST_IP:   rules[rule_idx].dst_ip   <= rule_wdata;
        DST_PORT: rules[rule_idx].dst_port <= rule_wdata[PORT_W-1:0];
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rule <= rules[rd_idx];
    end
  end

endmodule

`default_nettype wire

// ==== src/stream_reg.sv ====
/*
 * One-entry valid/ready register stage, generic over the payload type.
 */
`default_nettype none

module stream_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rstn,
  input  payload_t in,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out,
  output logic     out_valid,
  input  logic     out_ready
);

  // Free when empty or when the held item leaves this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready && in_valid) begin
      out <= in;
    end
  end

endmodule

`default_nettype wire

// ==== src/tuple_matcher.sv ====
/*
 * Wildcard tuple compare. Keeps the first matching rule as flow index+1.
 */
`default_nettype none

module tuple_matcher
  import flow_pkg::*;
#(
  parameter int FLOW_NUM  = 16,
  localparam int FLOW_BITS = $clog2(FLOW_NUM)
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 load,
  input  flow_tuple_t          tuple,
  input  flow_tuple_t          rule,
  input  logic                 rule_valid,
  input  logic [FLOW_BITS-1:0] rule_idx_q,
  output logic [FLOW_W-1:0]    flow
);

  flow_tuple_t key;
  logic        hit;

  // A zero rule field matches anything
  assign hit = ((rule.src_ip   == '0) || (rule.src_ip   == key.src_ip))   &&
               ((rule.src_port == '0) || (rule.src_port == key.src_port)) &&
               ((rule.dst_ip   == '0) || (rule.dst_ip   == key.dst_ip))   &&
               ((rule.dst_port == '0) || (rule.dst_port == key.dst_port));

  always_ff @(posedge clk) begin
    if (load) begin
      key <= tuple;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn || load) begin
      flow <= '0;
    end else if (rule_valid && (flow == '0) && hit) begin
      flow <= FLOW_W'(rule_idx_q) + FLOW_W'(1);
    end
  end

endmodule

`default_nettype wire
